// File: Bender.yml
package:
  name: trace_buffer

sources:
  - include_dirs:
      - src
    files:
      - src/trace_pkg.sv
      - src/dpram_sync.sv
      - src/capture_ctrl.sv
      - src/ring_counter.sv
      - src/readout_port.sv
      - src/trace_buffer_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/trace_buffer_tb.sv

// File: sources.f
+incdir+src
src/trace_pkg.sv
src/dpram_sync.sv
src/capture_ctrl.sv
src/ring_counter.sv
src/readout_port.sv
src/trace_buffer_top.sv
tb/trace_buffer_tb.sv

// File: src/capture_ctrl.sv
//------------------------------
// Capture FSM: arm, pre-trigger,
// post-trigger and done
//------------------------------
`timescale 1ns/1ps

module capture_ctrl (
  input  logic                      rclk,
  input  logic                      rst_n,
  input  logic                      arm,
  input  logic                      sample_valid,
  input  logic                      trigger,
  input  trace_pkg::ring_state_t    ring,
  output trace_pkg::ring_cmd_t      cmd,
  output trace_pkg::capture_state_e state
);

  import trace_pkg::*;

  capture_state_e state_q;
  capture_state_e state_d;

  //------------------------------
  // State register
  //------------------------------
  always_ff @(posedge rclk) begin
    if (!rst_n) begin
      state_q <= CAP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //------------------------------
  // Next state and ring commands
  //------------------------------
  // post_zero from the ring means the next qualifying sample is the last one.
  // Before the trigger that is the trigger sample itself (post_len of zero)
  always_comb begin
    state_d = state_q;
    cmd     = '0;
    case (state_q)
      CAP_IDLE, CAP_DONE: begin
        // Arm restarts from an empty ring
        if (arm) begin
          cmd.clear = 1'b1;
          state_d   = CAP_PRE;
        end
      end
      CAP_PRE: begin
        if (sample_valid) begin
          cmd.write = 1'b1;
          // Trigger counts only with a valid sample
          if (trigger) begin
            cmd.load_post = 1'b1;
            if (ring.post_zero) begin
              state_d = CAP_DONE;
            end else begin
              state_d = CAP_POST;
            end
          end
        end
      end
      CAP_POST: begin
        if (sample_valid) begin
          cmd.write = 1'b1;
          // Last post-trigger sample
          if (ring.post_zero) begin
            state_d = CAP_DONE;
          end
        end
      end
      default: begin
        state_d = CAP_IDLE;
      end
    endcase
  end

  assign state = state_q;

  //------------------------------
  // Checks
  //------------------------------
  // Nothing reaches the RAM outside a capture, so the ring stays put
  a_write_in_capture: assert property (
    @(posedge rclk) disable iff (!rst_n)
    (state_q == CAP_IDLE || state_q == CAP_DONE) && !arm |=> $stable(ring.wr_ptr)
  ) else $error("capture_ctrl: write outside capture");

  // Clear only on arm, and the ring is empty once capture starts
  a_clear_on_arm: assert property (
    @(posedge rclk) disable iff (!rst_n)
    cmd.clear |-> arm ##1 (state_q == CAP_PRE && ring.fill == '0)
  ) else $error("capture_ctrl: clear without arm or ring not emptied");

endmodule

// File: src/dpram_sync.sv
//------------------------------
// Dual-port RAM with one write port
// and a registered, enabled read port
//------------------------------
`timescale 1ns/1ps
`include "trace_macros.svh"

module dpram_sync (
  input  logic                 rclk,
  input  logic                 wen,
  input  logic [`TRACE_AW-1:0] waddr,
  input  logic [`TRACE_DW-1:0] wdata,
  input  logic                 ren,
  input  logic [`TRACE_AW-1:0] raddr,
  output logic [`TRACE_DW-1:0] rdata
);

  logic [`TRACE_DW-1:0] mem [`TRACE_DEPTH];

  //------------------------------
  // Write port
  //------------------------------
  always_ff @(posedge rclk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  //------------------------------
  // Read port
  //------------------------------
  // Output register keeps the last word while ren is low
  always_ff @(posedge rclk) begin
    if (ren) begin
      rdata <= mem[raddr];
    end
  end

  // Capture writes and readout reads belong to different phases
  a_no_rw_overlap: assert property (
    @(posedge rclk) (wen !== 1'b1) || (ren !== 1'b1)
  ) else $error("dpram_sync: write and read enabled in the same cycle");

endmodule

// File: src/readout_port.sv
//------------------------------
// Index to address mapping, read checks
// and the registered read response
//------------------------------
`timescale 1ns/1ps
`include "trace_macros.svh"

module readout_port (
  input  logic                      rclk,
  input  logic                      rst_n,
  input  trace_pkg::rd_req_t        req,
  input  trace_pkg::capture_state_e state,
  input  trace_pkg::ring_state_t    ring,
  output logic                      ren,
  output logic [`TRACE_AW-1:0]      raddr,
  input  logic [`TRACE_DW-1:0]      rdata,
  output trace_pkg::rd_rsp_t        rsp
);

  import trace_pkg::*;

  logic [`TRACE_AW-1:0] oldest;
  logic                 in_range;
  logic                 rd_ok;
  logic                 rsp_valid_q;
  logic                 rsp_err_q;

  // Oldest kept entry sits fill places behind the write pointer
  assign oldest   = ring.wr_ptr - ring.fill[`TRACE_AW-1:0];
  assign raddr    = oldest + req.index;
  assign in_range = ({1'b0, req.index} < ring.fill);
  assign rd_ok    = (state == CAP_DONE) && in_range;
  assign ren      = req.req && rd_ok;

  // Flags line up with the RAM output register
  always_ff @(posedge rclk) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= req.req;
      rsp_err_q   <= req.req && !rd_ok;
    end
  end

  assign rsp.valid = rsp_valid_q;
  assign rsp.err   = rsp_err_q;
  assign rsp.data  = (rsp_valid_q && !rsp_err_q) ? rdata : '0;

  // Every request answered on the next cycle and never otherwise
  a_rsp_latency: assert property (
    @(posedge rclk) disable iff (!rst_n)
    req.req |=> rsp.valid
  ) else $error("readout_port: request without response");

  a_rsp_no_spurious: assert property (
    @(posedge rclk) disable iff (!rst_n)
    !req.req |=> !rsp.valid
  ) else $error("readout_port: response without request");

endmodule

// File: src/ring_counter.sv
//------------------------------
// Write pointer, fill level and
// post-trigger countdown
//------------------------------
`timescale 1ns/1ps
`include "trace_macros.svh"

module ring_counter (
  input  logic                   rclk,
  input  logic                   rst_n,
  input  trace_pkg::ring_cmd_t   cmd,
  input  logic [`TRACE_AW-1:0]   post_len,
  output trace_pkg::ring_state_t ring
);

  logic [`TRACE_AW-1:0] wr_ptr_q;
  logic [`TRACE_AW:0]   fill_q;
  logic [`TRACE_AW-1:0] post_cnt_q;
  logic                 counting_q;

  //------------------------------
  // Pointer and fill
  //------------------------------
  always_ff @(posedge rclk) begin
    if (!rst_n || cmd.clear) begin
      wr_ptr_q   <= '0;
      fill_q     <= '0;
      counting_q <= 1'b0;
    end else begin
      if (cmd.write) begin
        // Pointer wraps, fill stops at full depth
        wr_ptr_q <= wr_ptr_q + 1'b1;
        if (fill_q != `TRACE_DEPTH) begin
          fill_q <= fill_q + 1'b1;
        end
      end
      if (cmd.load_post) begin
        counting_q <= 1'b1;
      end
    end
  end

  //------------------------------
  // Post-trigger countdown
  //------------------------------
  // Before the trigger the counter follows post_len, so a zero length shows
  // up as post_zero on the trigger sample. After the trigger it holds the
  // samples still owed beyond the next one
  always_ff @(posedge rclk) begin
    if (!rst_n) begin
      post_cnt_q <= '0;
    end else if (cmd.load_post) begin
      post_cnt_q <= post_len - 1'b1;
    end else if (!counting_q) begin
      post_cnt_q <= post_len;
    end else if (cmd.write && post_cnt_q != '0) begin
      post_cnt_q <= post_cnt_q - 1'b1;
    end
  end

  assign ring.wr_ptr    = wr_ptr_q;
  assign ring.fill      = fill_q;
  assign ring.post_zero = (post_cnt_q == '0);

  // Fill never above depth, and tracks the pointer until the ring is full
  a_fill_bound: assert property (
    @(posedge rclk) disable iff (!rst_n)
    (fill_q <= `TRACE_DEPTH) &&
    (fill_q == `TRACE_DEPTH || fill_q[`TRACE_AW-1:0] == wr_ptr_q)
  ) else $error("ring_counter: fill above depth or out of step with pointer");

endmodule

// File: src/trace_buffer_top.sv
//------------------------------
// Trace buffer top: FSM, ring counter,
// trace RAM and readout
//------------------------------
`timescale 1ns/1ps

module trace_buffer_top (
  input  logic                 rclk,
  input  logic                 rst_n,
  input  logic                 arm,
  input  trace_pkg::sample_t   sample_in,
  input  logic                 trigger,
  input  logic [`TRACE_AW-1:0] post_len,
  input  trace_pkg::rd_req_t   rd_req,
  output trace_pkg::rd_rsp_t   rd_rsp,
  output trace_pkg::status_t   status
);

  import trace_pkg::*;

  ring_cmd_t            cmd;
  ring_state_t          ring;
  capture_state_e       state;
  logic                 ram_ren;
  logic [`TRACE_AW-1:0] ram_raddr;
  logic [`TRACE_DW-1:0] ram_rdata;

  capture_ctrl u_ctrl (
    .rclk         (rclk),
    .rst_n        (rst_n),
    .arm          (arm),
    .sample_valid (sample_in.valid),
    .trigger      (trigger),
    .ring         (ring),
    .cmd          (cmd),
    .state        (state)
  );

  ring_counter u_ring (
    .rclk     (rclk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .post_len (post_len),
    .ring     (ring)
  );

  // Sample goes in at the current write pointer on the same edge
  dpram_sync u_ram (
    .rclk  (rclk),
    .wen   (cmd.write),
    .waddr (ring.wr_ptr),
    .wdata (sample_in.data),
    .ren   (ram_ren),
    .raddr (ram_raddr),
    .rdata (ram_rdata)
  );

  readout_port u_readout (
    .rclk  (rclk),
    .rst_n (rst_n),
    .req   (rd_req),
    .state (state),
    .ring  (ring),
    .ren   (ram_ren),
    .raddr (ram_raddr),
    .rdata (ram_rdata),
    .rsp   (rd_rsp)
  );

  assign status.state = state;
  assign status.done  = (state == CAP_DONE);
  assign status.fill  = ring.fill;

endmodule

// File: src/trace_macros.svh
//------------------------------
// Trace buffer size macros
// Depth, address width, sample width
//------------------------------
`ifndef TRACE_MACROS_SVH
`define TRACE_MACROS_SVH

// Entries in the trace RAM
`define TRACE_DEPTH 1024

// Address width for TRACE_DEPTH entries
`define TRACE_AW 10

// Width of one stored sample
`define TRACE_DW 8

`endif

// File: src/trace_pkg.sv
//------------------------------
// Capture state enum and the packed
// structs passed between trace blocks
//------------------------------
`include "trace_macros.svh"

package trace_pkg;

  typedef enum logic [1:0] {
    CAP_IDLE = 2'd0,
    CAP_PRE  = 2'd1,
    CAP_POST = 2'd2,
    CAP_DONE = 2'd3
  } capture_state_e;

  // One incoming sample with its strobe
  typedef struct packed {
    logic                 valid;
    logic [`TRACE_DW-1:0] data;
  } sample_t;

  // Read request, index counted from oldest entry
  typedef struct packed {
    logic                 req;
    logic [`TRACE_AW-1:0] index;
  } rd_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 err;
    logic [`TRACE_DW-1:0] data;
  } rd_rsp_t;

  // Pointer, fill level and end-of-capture flag
  typedef struct packed {
    logic [`TRACE_AW-1:0] wr_ptr;
    logic [`TRACE_AW:0]   fill;
    logic                 post_zero;
  } ring_state_t;

  typedef struct packed {
    logic clear;
    logic write;
    logic load_post;
  } ring_cmd_t;

  typedef struct packed {
    capture_state_e     state;
    logic               done;
    logic [`TRACE_AW:0] fill;
  } status_t;

endpackage

// File: tb/trace_buffer_tb.sv
//------------------------------
// Trace buffer testbench: case table,
// reference model, LFSR data and checks
//------------------------------
`timescale 1ns/1ps
`include "trace_macros.svh"

module trace_buffer_tb;

  import trace_pkg::*;

  typedef struct packed {
    logic [`TRACE_AW-1:0] post_len;
    logic [15:0]          pre_cnt;
    logic [7:0]           gap;
    logic                 early_rd;
    logic                 oor_rd;
  } case_row_t;

  localparam int NUM_CASES = 6;

  logic                 rclk;
  logic                 rst_n;
  logic                 arm;
  sample_t              sample_in;
  logic                 trigger;
  logic [`TRACE_AW-1:0] post_len;
  rd_req_t              rd_req;
  rd_rsp_t              rd_rsp;
  status_t              status;

  case_row_t   cases [NUM_CASES];
  logic [31:0] lfsr;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;

  // Reference model of the kept history, oldest entry first
  logic [`TRACE_DW-1:0] model_q [$];
  capture_state_e       model_state;
  int unsigned          model_left;

  trace_buffer_top u_dut (
    .rclk      (rclk),
    .rst_n     (rst_n),
    .arm       (arm),
    .sample_in (sample_in),
    .trigger   (trigger),
    .post_len  (post_len),
    .rd_req    (rd_req),
    .rd_rsp    (rd_rsp),
    .status    (status)
  );

  initial begin
    rclk = 1'b0;
    forever #4 rclk = ~rclk;
  end

  //------------------------------
  // Failure handling and compares
  //------------------------------
  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_rsp(input rd_rsp_t exp);
    if (rd_rsp !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t rd_rsp expected %h actual %h",
                                  $time, exp, rd_rsp));
    end
  endtask

  task automatic check_status(input status_t exp);
    if (status !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t status expected %h actual %h",
                                  $time, exp, status));
    end
  endtask

  // Watchdog, limit set from the case table before reset is released
  initial begin
    cycle_cnt = 0;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge rclk);
      cycle_cnt++;
      if (cycle_cnt >= cycle_limit) begin
        stop_with_failure("Timeout: the test did not finish within the cycle limit");
      end
    end
  end

  //------------------------------
  // LFSR data
  //------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int b = 0; b < n; b++) begin
      bits[b] = lfsr[0];
      lfsr    = lfsr_next(lfsr);
    end
  endtask

  //------------------------------
  // Reference model
  //------------------------------
  task automatic model_sample(input logic valid, input logic trig,
                              input logic [`TRACE_DW-1:0] data);
    if (valid && (model_state == CAP_PRE || model_state == CAP_POST)) begin
      model_q.push_back(data);
      if (model_q.size() > `TRACE_DEPTH) begin
        void'(model_q.pop_front());
      end
      if (model_state == CAP_PRE) begin
        if (trig) begin
          model_left  = post_len;
          model_state = (post_len == 0) ? CAP_DONE : CAP_POST;
        end
      end else begin
        model_left--;
        if (model_left == 0) begin
          model_state = CAP_DONE;
        end
      end
    end
  endtask

  function automatic status_t model_status();
    status_t s;
    s.state = model_state;
    s.done  = (model_state == CAP_DONE);
    s.fill  = (`TRACE_AW+1)'(model_q.size());
    return s;
  endfunction

  function automatic rd_rsp_t model_rsp(input logic [`TRACE_AW-1:0] index);
    rd_rsp_t r;
    r.valid = 1'b1;
    r.err   = (model_state != CAP_DONE) || (index >= model_q.size());
    r.data  = r.err ? '0 : model_q[index];
    return r;
  endfunction

  //------------------------------
  // Stimulus tasks
  //------------------------------
  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge rclk);
    #1;
  endtask

  task automatic arm_capture(input case_row_t row);
    post_len = row.post_len;
    arm      = 1'b1;
    step();
    arm = 1'b0;
    model_q.delete();
    model_state = CAP_PRE;
    check_status(model_status());
  endtask

  // Read while capturing must come back as an error
  task automatic early_read();
    rd_req.req   = 1'b1;
    rd_req.index = '0;
    step();
    rd_req = '0;
    check_rsp(model_rsp('0));
    check_status(model_status());
  endtask

  task automatic stream_capture(input case_row_t row);
    int unsigned sent;
    int unsigned run;
    logic [31:0] bits;
    logic        valid;
    logic        trig;
    sent = 0;
    run  = 0;
    while (model_state != CAP_DONE) begin
      take_bits(`TRACE_DW + 1, bits);
      valid = 1'b1;
      trig  = 1'b0;
      if (row.gap != 0 && run == row.gap) begin
        // Idle cycle with trigger high, must not count
        valid = 1'b0;
        trig  = 1'b1;
        run   = 0;
      end else if (model_state == CAP_PRE) begin
        trig = (sent == row.pre_cnt);
        sent++;
        run++;
      end else begin
        trig = bits[`TRACE_DW];
        run++;
      end
      sample_in.valid = valid;
      sample_in.data  = bits[`TRACE_DW-1:0];
      trigger         = trig;
      model_sample(valid, trig, bits[`TRACE_DW-1:0]);
      step();
      check_status(model_status());
    end
    // Sample after done is dropped
    sample_in.valid = 1'b1;
    trigger         = 1'b1;
    step();
    check_status(model_status());
    sample_in = '0;
    trigger   = 1'b0;
  endtask

  // Back-to-back reads, each response checked on the cycle after its request
  task automatic readback(input case_row_t row);
    logic [`TRACE_AW-1:0] idx [$];
    int unsigned          n;
    n = model_q.size();
    for (int i = 0; i < n; i++) begin
      idx.push_back(i);
    end
    if (n < `TRACE_DEPTH) begin
      idx.push_back(n);
    end
    if (row.oor_rd && n < `TRACE_DEPTH - 1) begin
      idx.push_back(`TRACE_DEPTH - 1);
    end
    for (int k = 0; k < idx.size(); k++) begin
      rd_req.req   = 1'b1;
      rd_req.index = idx[k];
      step();
      check_rsp(model_rsp(idx[k]));
    end
    rd_req = '0;
  endtask

  //------------------------------
  // Main sequence
  //------------------------------
  initial begin
    // post_len, pre samples, gap spacing, early read, out-of-range read
    cases[0] = '{10'd5,   16'd10,   8'd0, 1'b0, 1'b0};  // short, no wrap
    cases[1] = '{10'd300, 16'd900,  8'd0, 1'b0, 1'b0};  // wraps past depth
    cases[2] = '{10'd0,   16'd7,    8'd0, 1'b1, 1'b1};  // zero post length
    cases[3] = '{10'd12,  16'd20,   8'd3, 1'b0, 1'b1};  // gaps with trigger high
    cases[4] = '{10'd40,  16'd1500, 8'd7, 1'b1, 1'b0};
    cases[5] = '{10'd3,   16'd2,    8'd0, 1'b0, 1'b1};  // small after big
    lfsr        = 32'he781;
    cycle_limit = 20000;
    foreach (cases[c]) begin
      cycle_limit += 2 * (cases[c].pre_cnt + cases[c].post_len + 1);
    end
    rst_n       = 1'b0;
    arm         = 1'b0;
    sample_in   = '0;
    trigger     = 1'b0;
    post_len    = '0;
    rd_req      = '0;
    model_state = CAP_IDLE;
    model_left  = 0;
    repeat (3) @(posedge rclk);
    #1;
    check_status(model_status());
    rst_n = 1'b1;
    for (int c = 0; c < NUM_CASES; c++) begin
      arm_capture(cases[c]);
      if (cases[c].early_rd) begin
        early_read();
      end
      stream_capture(cases[c]);
      readback(cases[c]);
    end
    $display("No errors");
    $finish;
  end

endmodule
